/* design/avl_bus_pkg.sv */
`default_nettype none

package avl_bus_pkg;

  // interconnect size.
  localparam int master_num = 4;  // masters sharing the one slave.
  localparam int sel_w      = 2;  // width of a master index.

  // command fields.
  localparam int addr_w  = 16;  // word address.
  localparam int data_w  = 32;  // write and read data.

  // bursts.
  localparam int burst_max = 8;  // longest burst in beats.
  localparam int burst_w   = 4;  // beat count field, holds burst_max.

endpackage

`default_nettype wire

/* design/avl_bus_priority_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module avl_bus_priority_encoder (
  input  logic [avl_bus_pkg::master_num-1:0] req_vec,  // one bit per candidate.
  output logic [avl_bus_pkg::sel_w-1:0]      idx,      // lowest set bit.
  output logic                               any       // some bit is set.
);

  // walk from the top down so the lowest set bit is the last to win.
  always_comb begin
    idx = '0;   // zero when nothing is set.
    any = 1'b0;
    for (int k = avl_bus_pkg::master_num - 1; k >= 0; k--) begin
      if (req_vec[k]) begin
        idx = avl_bus_pkg::sel_w'(k);
        any = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/avl_bus_n21_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module avl_bus_n21_arb (
  input  logic                               clk,
  input  logic                               rest,
  input  logic [avl_bus_pkg::master_num-1:0] request,        // full buffers.
  input  logic                               s_read,
  input  logic                               s_write,
  input  logic                               s_begin_burst,
  input  logic [avl_bus_pkg::burst_w-1:0]    s_burst_count,
  input  logic                               s_ready,
  output logic [avl_bus_pkg::sel_w-1:0]      sel             // granted port.
);

  logic [avl_bus_pkg::sel_w-1:0]        last_sel;   // port of the last accepted beat.
  logic [avl_bus_pkg::sel_w-1:0]        start;      // port with top priority now.
  logic [avl_bus_pkg::sel_w-1:0]        sel_buff;   // sel of the previous cycle.
  logic [avl_bus_pkg::sel_w-1:0]        now_sel;    // fresh round-robin choice.
  logic [avl_bus_pkg::sel_w-1:0]        enc_idx;
  logic                                 enc_any;
  logic [2*avl_bus_pkg::master_num-1:0] req_dbl;
  logic [avl_bus_pkg::master_num-1:0]   req_rot;
  logic [avl_bus_pkg::burst_w-1:0]      burst_cnt;  // beats left in a locked burst.
  logic                                 stall_hold; // slave held the last command.
  logic                                 cmd_valid;
  logic                                 beat_ok;

  assign cmd_valid = s_read || s_write;
  assign beat_ok   = cmd_valid && s_ready;  // slave takes a beat.

  // rotate so that the port after last_sel sits at bit 0.
  assign start   = last_sel + 1'b1;  // index width wraps modulo master_num.
  assign req_dbl = {request, request};
  assign req_rot = avl_bus_pkg::master_num'(req_dbl >> start);

  avl_bus_priority_encoder u_enc (
    .req_vec (req_rot),
    .idx     (enc_idx),
    .any     (enc_any)
  );

  // undo the rotation, same wrap.
  assign now_sel = !enc_any ? last_sel :  // idle, park on the last owner.
                   enc_idx + start;

  // frozen during a burst and while the slave stalls a command.
  assign sel = (burst_cnt != '0 || stall_hold) ? sel_buff : now_sel;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      last_sel   <= avl_bus_pkg::sel_w'(avl_bus_pkg::master_num - 1);  // port 0 first.
      sel_buff   <= '0;
      burst_cnt  <= '0;
      stall_hold <= 1'b0;
    end else begin
      sel_buff   <= sel;                   // holds itself while locked.
      stall_hold <= cmd_valid && !s_ready;
      if (beat_ok) begin
        last_sel <= sel;
        if (burst_cnt != '0)
          burst_cnt <= burst_cnt - 1'b1;   // one more beat done.
        else if (s_begin_burst && s_burst_count > 1)
          burst_cnt <= s_burst_count - 1'b1;  // first beat already taken.
      end
    end
  end

  // burst owner cannot change until the last beat.
  sel_locked_a : assert property (@(posedge clk) disable iff (!rest)
    burst_cnt != '0 |-> sel == last_sel);

  cnt_range_a : assert property (@(posedge clk) disable iff (!rest)
    burst_cnt != '0 |-> burst_cnt <= avl_bus_pkg::burst_max);

endmodule

`default_nettype wire

/* design/avl_bus_master_port.sv */
`timescale 1ns/1ps
`default_nettype none

module avl_bus_master_port (
  input  logic                            clk,
  input  logic                            rest,
  // master side.
  input  logic                            m_read,
  input  logic                            m_write,
  input  logic [avl_bus_pkg::addr_w-1:0]  m_address,
  input  logic [avl_bus_pkg::data_w-1:0]  m_writedata,
  input  logic                            m_begin_burst,
  input  logic [avl_bus_pkg::burst_w-1:0] m_burst_count,
  output logic                            m_waitrequest,
  output logic [avl_bus_pkg::data_w-1:0]  m_readdata,
  output logic                            m_readdatavalid,
  // interconnect side.
  output logic                            request,
  output logic                            p_read,
  output logic                            p_write,
  output logic [avl_bus_pkg::addr_w-1:0]  p_address,
  output logic [avl_bus_pkg::data_w-1:0]  p_writedata,
  output logic                            p_begin_burst,
  output logic [avl_bus_pkg::burst_w-1:0] p_burst_count,
  input  logic                            granted_ready,
  input  logic [avl_bus_pkg::data_w-1:0]  granted_readdata
);

  logic full;    // buffer holds a command.
  logic rd_q;
  logic wr_q;
  logic bb_q;
  logic take;

  assign take          = (m_read || m_write) && !full;  // command accepted here.
  assign m_waitrequest = full;                           // one entry only.
  assign request       = full;

  // qualifiers are masked so an empty buffer shows no command.
  assign p_read        = full && rd_q;
  assign p_write       = full && wr_q;
  assign p_begin_burst = full && bb_q;

  // control.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      full            <= 1'b0;
      m_readdatavalid <= 1'b0;
    end else begin
      m_readdatavalid <= granted_ready && rd_q;  // one-cycle pulse.
      if (granted_ready)
        full <= 1'b0;
      else if (take)
        full <= 1'b1;
    end
  end

  // payload.
  always_ff @(posedge clk) begin
    if (take) begin
      rd_q          <= m_read;
      wr_q          <= m_write;
      bb_q          <= m_begin_burst;
      p_address     <= m_address;
      p_writedata   <= m_writedata;
      p_burst_count <= m_burst_count;
    end
    if (granted_ready && rd_q)
      m_readdata <= granted_readdata;  // shared bus, only the owner latches.
  end

  one_kind_a : assert property (@(posedge clk) disable iff (!rest)
    take |-> !(m_read && m_write));

  // the mux may only answer a port that has something to answer.
  ready_when_full_a : assert property (@(posedge clk) disable iff (!rest)
    granted_ready |-> full);

endmodule

`default_nettype wire

/* design/avl_bus_cmd_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module avl_bus_cmd_mux (
  input  logic [avl_bus_pkg::sel_w-1:0]      sel,
  // buffered commands of all ports.
  input  logic [avl_bus_pkg::master_num-1:0] p_read,
  input  logic [avl_bus_pkg::master_num-1:0] p_write,
  input  logic [avl_bus_pkg::addr_w-1:0]     p_address     [avl_bus_pkg::master_num],
  input  logic [avl_bus_pkg::data_w-1:0]     p_writedata   [avl_bus_pkg::master_num],
  input  logic [avl_bus_pkg::master_num-1:0] p_begin_burst,
  input  logic [avl_bus_pkg::burst_w-1:0]    p_burst_count [avl_bus_pkg::master_num],
  // slave answer.
  input  logic                               s_ready,
  input  logic [avl_bus_pkg::data_w-1:0]     s_readdata,
  // slave command.
  output logic                               s_read,
  output logic                               s_write,
  output logic [avl_bus_pkg::addr_w-1:0]     s_address,
  output logic [avl_bus_pkg::data_w-1:0]     s_writedata,
  output logic                               s_begin_burst,
  output logic [avl_bus_pkg::burst_w-1:0]    s_burst_count,
  // back to the ports.
  output logic [avl_bus_pkg::master_num-1:0] granted_ready,
  output logic [avl_bus_pkg::data_w-1:0]     granted_readdata
);

  logic beat_ok;

  // forward path.
  assign s_read        = p_read[sel];
  assign s_write       = p_write[sel];
  assign s_address     = p_address[sel];
  assign s_writedata   = p_writedata[sel];
  assign s_begin_burst = p_begin_burst[sel];
  assign s_burst_count = p_burst_count[sel];

  assign beat_ok = s_ready && (s_read || s_write);  // slave takes the beat.

  // ready goes to the owner only, and only when a beat really moves.
  always_comb begin
    granted_ready = '0;
    for (int k = 0; k < avl_bus_pkg::master_num; k++) begin
      if (sel == avl_bus_pkg::sel_w'(k))
        granted_ready[k] = beat_ok;
    end
  end

  assign granted_readdata = s_readdata;  // broadcast to all ports.

endmodule

`default_nettype wire

/* design/avl_bus_n21.sv */
`timescale 1ns/1ps
`default_nettype none

module avl_bus_n21 (
  input  logic                               clk,
  input  logic                               rest,
  // master pins, one slot per master.
  input  logic [avl_bus_pkg::master_num-1:0] m_read,
  input  logic [avl_bus_pkg::master_num-1:0] m_write,
  input  logic [avl_bus_pkg::addr_w-1:0]     m_address     [avl_bus_pkg::master_num],
  input  logic [avl_bus_pkg::data_w-1:0]     m_writedata   [avl_bus_pkg::master_num],
  input  logic [avl_bus_pkg::master_num-1:0] m_begin_burst,
  input  logic [avl_bus_pkg::burst_w-1:0]    m_burst_count [avl_bus_pkg::master_num],
  output logic [avl_bus_pkg::master_num-1:0] m_waitrequest,
  output logic [avl_bus_pkg::data_w-1:0]     m_readdata    [avl_bus_pkg::master_num],
  output logic [avl_bus_pkg::master_num-1:0] m_readdatavalid,
  // slave pins.
  output logic                               s_read,
  output logic                               s_write,
  output logic [avl_bus_pkg::addr_w-1:0]     s_address,
  output logic [avl_bus_pkg::data_w-1:0]     s_writedata,
  output logic                               s_begin_burst,
  output logic [avl_bus_pkg::burst_w-1:0]    s_burst_count,
  input  logic                               s_ready,
  input  logic [avl_bus_pkg::data_w-1:0]     s_readdata
);

  logic [avl_bus_pkg::master_num-1:0] request;
  logic [avl_bus_pkg::master_num-1:0] p_read;
  logic [avl_bus_pkg::master_num-1:0] p_write;
  logic [avl_bus_pkg::addr_w-1:0]     p_address     [avl_bus_pkg::master_num];
  logic [avl_bus_pkg::data_w-1:0]     p_writedata   [avl_bus_pkg::master_num];
  logic [avl_bus_pkg::master_num-1:0] p_begin_burst;
  logic [avl_bus_pkg::burst_w-1:0]    p_burst_count [avl_bus_pkg::master_num];
  logic [avl_bus_pkg::master_num-1:0] granted_ready;
  logic [avl_bus_pkg::data_w-1:0]     granted_readdata;
  logic [avl_bus_pkg::sel_w-1:0]      sel;

  // one command buffer per master.
  for (genvar i = 0; i < avl_bus_pkg::master_num; i++) begin : g_port
    avl_bus_master_port u_port (
      .clk              (clk),
      .rest             (rest),
      .m_read           (m_read[i]),
      .m_write          (m_write[i]),
      .m_address        (m_address[i]),
      .m_writedata      (m_writedata[i]),
      .m_begin_burst    (m_begin_burst[i]),
      .m_burst_count    (m_burst_count[i]),
      .m_waitrequest    (m_waitrequest[i]),
      .m_readdata       (m_readdata[i]),
      .m_readdatavalid  (m_readdatavalid[i]),
      .request          (request[i]),
      .p_read           (p_read[i]),
      .p_write          (p_write[i]),
      .p_address        (p_address[i]),
      .p_writedata      (p_writedata[i]),
      .p_begin_burst    (p_begin_burst[i]),
      .p_burst_count    (p_burst_count[i]),
      .granted_ready    (granted_ready[i]),
      .granted_readdata (granted_readdata)
    );
  end

  avl_bus_n21_arb u_arb (
    .clk           (clk),
    .rest          (rest),
    .request       (request),
    .s_read        (s_read),
    .s_write       (s_write),
    .s_begin_burst (s_begin_burst),
    .s_burst_count (s_burst_count),
    .s_ready       (s_ready),
    .sel           (sel)
  );

  avl_bus_cmd_mux u_mux (
    .sel              (sel),
    .p_read           (p_read),
    .p_write          (p_write),
    .p_address        (p_address),
    .p_writedata      (p_writedata),
    .p_begin_burst    (p_begin_burst),
    .p_burst_count    (p_burst_count),
    .s_ready          (s_ready),
    .s_readdata       (s_readdata),
    .s_read           (s_read),
    .s_write          (s_write),
    .s_address        (s_address),
    .s_writedata      (s_writedata),
    .s_begin_burst    (s_begin_burst),
    .s_burst_count    (s_burst_count),
    .granted_ready    (granted_ready),
    .granted_readdata (granted_readdata)
  );

endmodule

`default_nettype wire

/* tests/avl_bus_n21_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module avl_bus_n21_tb;

  localparam int period_ns       = 4;
  localparam int cmds_per_master = 28;  // 8 round robin, 8 burst, 12 mixed.
  localparam int stall_bound     = 16;  // worst-case cycles one beat waits on the slave.
  localparam int watchdog_ns     = cmds_per_master * avl_bus_pkg::master_num
                                   * avl_bus_pkg::master_num * stall_bound * period_ns;
  localparam int low_w = avl_bus_pkg::addr_w - avl_bus_pkg::sel_w;  // address below source.
  localparam int cmd_w = 3 + avl_bus_pkg::burst_w + avl_bus_pkg::addr_w
                         + avl_bus_pkg::data_w;  // {read, write, begin, count, addr, data}.

  logic                               clk;
  logic                               rest;
  logic [avl_bus_pkg::master_num-1:0] m_read;
  logic [avl_bus_pkg::master_num-1:0] m_write;
  logic [avl_bus_pkg::addr_w-1:0]     m_address     [avl_bus_pkg::master_num];
  logic [avl_bus_pkg::data_w-1:0]     m_writedata   [avl_bus_pkg::master_num];
  logic [avl_bus_pkg::master_num-1:0] m_begin_burst;
  logic [avl_bus_pkg::burst_w-1:0]    m_burst_count [avl_bus_pkg::master_num];
  logic [avl_bus_pkg::master_num-1:0] m_waitrequest;
  logic [avl_bus_pkg::data_w-1:0]     m_readdata    [avl_bus_pkg::master_num];
  logic [avl_bus_pkg::master_num-1:0] m_readdatavalid;
  logic                               s_read;
  logic                               s_write;
  logic [avl_bus_pkg::addr_w-1:0]     s_address;
  logic [avl_bus_pkg::data_w-1:0]     s_writedata;
  logic                               s_begin_burst;
  logic [avl_bus_pkg::burst_w-1:0]    s_burst_count;
  logic                               s_ready;
  logic [avl_bus_pkg::data_w-1:0]     s_readdata;

  logic [cmd_w-1:0]               cmd_q   [avl_bus_pkg::master_num][$];  // taken, not on bus.
  logic [avl_bus_pkg::addr_w-1:0] rd_pend [avl_bus_pkg::master_num][$];  // reads owed data.
  logic [31:0]                    slave_rng;
  logic                           any_issued;  // some master has driven a command.
  int                             pass_cnt;
  int                             fail_cnt;

  // checker view, written on the falling edge, sampled on the rising one.
  logic                            chk_cmd;
  logic                            cmd_found;
  logic                            chk_rr;
  logic                            chk_burst;
  logic                            chk_rdv;
  logic                            rdv_found;
  logic [cmd_w-1:0]                exp_cmd;
  logic [cmd_w-1:0]                got_cmd;
  logic [avl_bus_pkg::sel_w-1:0]   exp_src;
  logic [avl_bus_pkg::sel_w-1:0]   got_src;
  logic [avl_bus_pkg::sel_w-1:0]   burst_src;
  logic [avl_bus_pkg::sel_w-1:0]   last_src;
  logic [avl_bus_pkg::burst_w-1:0] burst_left;  // beats still owed to burst_src.
  logic [avl_bus_pkg::data_w-1:0]  exp_rdata;
  logic [avl_bus_pkg::data_w-1:0]  got_rdata;
  logic                            prev_stall;  // slave held a command last cycle.
  logic                            next_full;   // next port in turn waited as this one came up.

  avl_bus_n21 UUT (.*);

  always #(period_ns / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;  // numerical recipes constants.
  endfunction

  // slave model.
  assign s_readdata = ~avl_bus_pkg::data_w'(s_address);  // inverted, zero extended address.

  always @(posedge clk) begin
    slave_rng = lcg_next(slave_rng);
    s_ready  <= slave_rng[31:30] != 2'b00;  // ready about three cycles in four.
  end

  task automatic issue_cmd(input int m, input logic rd, input logic [low_w-1:0] a,
                           input logic [avl_bus_pkg::data_w-1:0] d, input logic bb,
                           input logic [avl_bus_pkg::burst_w-1:0] cnt);
    logic [avl_bus_pkg::addr_w-1:0] addr;
    addr = {avl_bus_pkg::sel_w'(m), a};  // source index in the top bits.
    @(posedge clk);
    any_issued       <= 1'b1;
    m_read[m]        <= rd;
    m_write[m]       <= !rd;
    m_address[m]     <= addr;
    m_writedata[m]   <= d;
    m_begin_burst[m] <= bb;
    m_burst_count[m] <= cnt;
    @(negedge clk);
    while (m_waitrequest[m])
      @(negedge clk);
    cmd_q[m].push_back({rd, !rd, bb, cnt, addr, d});  // taken on the coming edge.
    @(posedge clk);
    m_read[m]  <= 1'b0;
    m_write[m] <= 1'b0;
  endtask

  task automatic master_run(input int m, input int test);
    logic [31:0] rng;
    int          blen;
    rng  = 32'hf1ee + 32'(m + 1);  // own stream per master.
    blen = (m == 0) ? avl_bus_pkg::burst_max : avl_bus_pkg::burst_max / 2;
    for (int n = 0; n < 12; n++) begin
      rng = lcg_next(rng);
      if (test == 2 && n < 8)
        issue_cmd(m, 1'b0, rng[low_w-1:0], rng, 1'b0, 1);
      else if (test == 3 && n < 8)
        issue_cmd(m, 1'b0, rng[low_w-1:0], rng, (n % blen) == 0,
                  avl_bus_pkg::burst_w'(blen));  // master 0 runs one full-length burst.
      else if (test == 4)
        issue_cmd(m, rng[31], rng[low_w-1:0], ~rng, 1'b0, 1);
    end
  endtask

  function automatic logic drained();
    logic empty;
    empty = (m_waitrequest == '0);
    for (int k = 0; k < avl_bus_pkg::master_num; k++)
      empty = empty && cmd_q[k].size() == 0 && rd_pend[k].size() == 0;
    return empty;
  endfunction

  task automatic run_test(input int test, input string name);
    int fails_before;
    fails_before = fail_cnt;
    if (test == 1) begin
      repeat (10) @(posedge clk);  // idle bus only.
    end else begin
      fork
        master_run(0, test);
        master_run(1, test);
        master_run(2, test);
        master_run(3, test);
      join
    end
    while (!drained())
      @(negedge clk);
    repeat (3) @(posedge clk);  // last checks fire.
    $display("test %0d %s finished with %0d failures", test, name, fail_cnt - fails_before);
  endtask

  // bus monitor, looks one half cycle ahead of each accepting edge.
  always @(negedge clk) begin : monitor
    logic [avl_bus_pkg::sel_w-1:0] src;
    logic                          beat;
    src       = s_address[avl_bus_pkg::addr_w-1 -: avl_bus_pkg::sel_w];
    beat      = s_ready && (s_read || s_write);
    chk_cmd   = 1'b0;
    chk_rr    = 1'b0;
    chk_burst = 1'b0;
    chk_rdv   = 1'b0;
    if (!rest) begin
      last_src   = avl_bus_pkg::sel_w'(avl_bus_pkg::master_num - 1);  // port 0 wins first.
      burst_left = '0;
      prev_stall = 1'b0;
      next_full  = 1'b0;
    end else begin
      if ((s_read || s_write) && !prev_stall)
        next_full = m_waitrequest[avl_bus_pkg::sel_w'(last_src + 1'b1)];  // its turn, waiting.
      prev_stall = (s_read || s_write) && !s_ready;
      if (beat) begin
        got_src   = src;
        got_cmd   = {s_read, s_write, s_begin_burst, s_burst_count, s_address, s_writedata};
        chk_cmd   = 1'b1;
        cmd_found = cmd_q[src].size() != 0;
        if (cmd_found)
          exp_cmd = cmd_q[src].pop_front();  // oldest command of that master.
        if (burst_left != 0) begin
          chk_burst  = 1'b1;
          burst_left = burst_left - 1'b1;
        end else begin
          chk_rr  = next_full;
          exp_src = last_src + 1'b1;  // two-bit wrap, modulo master_num.
          if (s_begin_burst && s_burst_count > 1) begin
            burst_src  = src;
            burst_left = s_burst_count - 1'b1;  // first beat is this one.
          end
        end
        if (s_read)
          rd_pend[src].push_back(s_address);
        last_src = src;
      end
      for (int k = 0; k < avl_bus_pkg::master_num; k++) begin
        if (m_readdatavalid[k]) begin
          chk_rdv   = 1'b1;
          got_rdata = m_readdata[k];
          rdv_found = rd_pend[k].size() != 0;
          if (rdv_found)
            exp_rdata = ~avl_bus_pkg::data_w'(rd_pend[k].pop_front());
        end
      end
    end
  end

  idle_a : assert property (@(posedge clk) disable iff (!rest)
    !any_issued |-> {s_read, s_write, m_readdatavalid, m_waitrequest} == '0)
    pass_cnt++;
  else begin
    fail_cnt++;
    $display("[FAIL] %0t {s_read,s_write,m_readdatavalid,m_waitrequest} expected 0 got %b",
             $time, $sampled({s_read, s_write, m_readdatavalid, m_waitrequest}));
  end

  cmd_a : assert property (@(posedge clk) disable iff (!rest)
    chk_cmd |-> cmd_found && got_cmd == exp_cmd)
    pass_cnt++;
  else begin
    fail_cnt++;
    if (!cmd_found)
      $display("beat at %0t names master %0d, which had nothing outstanding", $time, got_src);
    else
      $display("[FAIL] %0t %s expected %h got %h", $time,
               "{s_read,s_write,s_begin_burst,s_burst_count,s_address,s_writedata}",
               exp_cmd, got_cmd);
  end

  rr_a : assert property (@(posedge clk) disable iff (!rest) chk_rr |-> got_src == exp_src)
    pass_cnt++;
  else begin
    fail_cnt++;
    $display("[FAIL] %0t s_address source expected %0d got %0d", $time, exp_src, got_src);
  end

  burst_a : assert property (@(posedge clk) disable iff (!rest)
    chk_burst |-> got_src == burst_src)
    pass_cnt++;
  else begin
    fail_cnt++;
    $display("[FAIL] %0t burst s_address source expected %0d got %0d",
             $time, burst_src, got_src);
  end

  rdv_a : assert property (@(posedge clk) disable iff (!rest)
    chk_rdv |-> rdv_found && got_rdata == exp_rdata)
    pass_cnt++;
  else begin
    fail_cnt++;
    if (!rdv_found)
      $display("m_readdatavalid pulsed at %0t with no read outstanding", $time);
    else
      $display("[FAIL] %0t m_readdata expected %h got %h", $time, exp_rdata, got_rdata);
  end

  one_rdv_a : assert property (@(posedge clk) disable iff (!rest) $onehot0(m_readdatavalid))
    pass_cnt++;
  else begin
    fail_cnt++;
    $display("[FAIL] %0t m_readdatavalid expected one hot or zero got %b",
             $time, $sampled(m_readdatavalid));
  end

  initial begin
    clk           = 1'b0;
    rest          = 1'b0;
    any_issued    = 1'b0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    slave_rng     = 32'hf1ee;
    s_ready       = 1'b0;
    m_read        = '0;
    m_write       = '0;
    m_begin_burst = '0;
    for (int k = 0; k < avl_bus_pkg::master_num; k++) begin
      m_address[k]     = '0;
      m_writedata[k]   = '0;
      m_burst_count[k] = '0;
    end
    repeat (5) @(posedge clk);
    rest <= 1'b1;
    run_test(1, "reset idle");
    run_test(2, "round robin");
    run_test(3, "burst lock");
    run_test(4, "mixed read write");
    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // hang guard.
  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the bus never finished its commands",
             watchdog_ns);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
design/avl_bus_pkg.sv
design/avl_bus_priority_encoder.sv
design/avl_bus_n21_arb.sv
design/avl_bus_master_port.sv
design/avl_bus_cmd_mux.sv
design/avl_bus_n21.sv
tests/avl_bus_n21_tb.sv
